// File: source/z_buffer_pkg.sv
/*
 * Z buffer shared types
 */

package z_buffer_pkg;

  // Half precision element width
  localparam int unsigned ELEM_W = 16;

  // Counter width, covers Depth and Width up to 255
  localparam int unsigned CNT_W = 8;

  // One FP16 element, raw bits only
  typedef logic [ELEM_W-1:0] elem_t;

  // Column, row and beat counters, also the leftover count
  typedef logic [CNT_W-1:0] cnt_t;

  // Buffer phases
  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,  // Waiting for start
    PH_LOAD  = 2'd1,  // Memory beats fill the columns
    PH_PUSH  = 2'd2,  // Rows go to the array, results come back
    PH_STORE = 2'd3   // Columns leave as store beats
  } phase_e;

endpackage : z_buffer_pkg

// File: source/z_row_loader.sv
/*
 * Z buffer row loader
 */

module z_row_loader
  import z_buffer_pkg::*;
#(
  parameter int unsigned Depth = 4,
  parameter int unsigned Width = 4
) (
  input  logic                   buffer_clock,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   load_en_i,
  input  logic                   y_valid_i,
  input  elem_t [Depth-1:0]      y_data_i,
  input  cnt_t                   depth_i,
  output logic                   load_we_o,
  output cnt_t                   load_col_o,
  output elem_t [Depth-1:0]      load_data_o,
  output logic                   loaded_o
);

  cnt_t col_q;  // Next column to write
  logic last_col;

  // A beat is taken on every valid cycle of the load phase
  assign load_we_o  = load_en_i & y_valid_i;
  assign load_col_o = col_q;

  // Elements beyond the leftover count are forced to zero
  always_comb begin
    for (int d = 0; d < Depth; d++) begin
      load_data_o[d] = (cnt_t'(d) < depth_i) ? y_data_i[d] : '0;
    end
  end

  assign last_col = (col_q == cnt_t'(Width - 1));
  assign loaded_o = load_we_o & last_col;

  always_ff @(posedge buffer_clock or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q <= '0;
    end else if (clear_i || loaded_o) begin
      col_q <= '0;  // Ready for the next tile
    end else if (load_we_o) begin
      col_q <= col_q + cnt_t'(1);
    end
  end

  // Once the last column is written the controller must leave the load
  // phase, so no further beat can land in a stale column
  a_load_ends: assert property (
    @(posedge buffer_clock) disable iff (!rst_ni || clear_i)
    loaded_o |=> !load_en_i
  ) else $error("load_en_i still high after the last column");

endmodule : z_row_loader

// File: source/z_tile_buffer.sv
/*
 * Z buffer tile storage
 */

module z_tile_buffer
  import z_buffer_pkg::*;
#(
  parameter int unsigned Depth = 4,
  parameter int unsigned Width = 4
) (
  input  logic                   buffer_clock,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  // Column write from the loader
  input  logic                   load_we_i,
  input  cnt_t                   load_col_i,
  input  elem_t [Depth-1:0]      load_data_i,
  // Row exchange with the array
  input  logic                   push_en_i,
  input  logic                   z_row_valid_i,
  input  elem_t [Width-1:0]      z_row_i,
  // Column shift toward the packer
  input  logic                   store_shift_i,
  output elem_t [Width-1:0]      y_row_o,
  output logic                   y_row_valid_o,
  output elem_t [Depth-1:0]      col_o,
  output logic                   pushed_o
);

  // Row index first, then column
  elem_t [Depth-1:0][Width-1:0] tile_q;

  logic push_shift;  // Top row leaves, result row enters
  cnt_t push_cnt_q;

  assign push_shift = push_en_i & z_row_valid_i;

  always_ff @(posedge buffer_clock or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q <= '0;
    end else if (clear_i) begin
      tile_q <= '0;
    end else if (push_shift) begin
      // Rows move up by one, the array result fills row zero
      for (int d = 0; d < Depth; d++) begin
        for (int w = 0; w < Width; w++) begin
          if (d == 0) begin
            tile_q[d][w] <= z_row_i[w];
          end else begin
            tile_q[d][w] <= tile_q[d-1][w];
          end
        end
      end
    end else if (store_shift_i) begin
      // Columns move toward column zero, zeros enter at the far end
      for (int d = 0; d < Depth; d++) begin
        for (int w = 0; w < Width; w++) begin
          if (w < Width - 1) begin
            tile_q[d][w] <= tile_q[d][w+1];
          end else begin
            tile_q[d][w] <= '0;
          end
        end
      end
    end else if (load_we_i) begin
      // Beat element d lands in row Depth-1-d
      for (int d = 0; d < Depth; d++) begin
        tile_q[Depth-1-d][load_col_i] <= load_data_i[d];
      end
    end
  end

  // Counts rows handed to the array during the push phase
  always_ff @(posedge buffer_clock or negedge rst_ni) begin
    if (!rst_ni) begin
      push_cnt_q <= '0;
    end else if (clear_i || pushed_o) begin
      push_cnt_q <= '0;
    end else if (push_shift) begin
      push_cnt_q <= push_cnt_q + cnt_t'(1);
    end
  end

  assign pushed_o = push_shift & (push_cnt_q == cnt_t'(Depth - 1));

  // Top row goes out, only meaningful in the push phase
  assign y_row_o       = push_en_i ? tile_q[Depth-1] : '0;
  assign y_row_valid_o = push_shift;

  // Column zero, in row order
  always_comb begin
    for (int d = 0; d < Depth; d++) begin
      col_o[d] = tile_q[d][0];
    end
  end

  // Loader, array and packer take turns on the tile
  a_one_writer: assert property (
    @(posedge buffer_clock) disable iff (!rst_ni)
    $onehot0({load_we_i, push_shift, store_shift_i})
  ) else $error("More than one tile write in a cycle");

endmodule : z_tile_buffer

// File: source/z_buffer_ctrl.sv
/*
 * Z buffer phase controller
 */

module z_buffer_ctrl
  import z_buffer_pkg::*;
#(
  parameter int unsigned Depth = 4
) (
  input  logic   buffer_clock,
  input  logic   rst_ni,
  input  logic   clear_i,
  input  logic   start_i,
  input  cnt_t   leftover_i,
  input  logic   loaded_i,   // Last column written
  input  logic   pushed_i,   // Last row exchanged
  input  logic   stored_i,   // Last beat accepted
  output logic   load_en_o,
  output logic   push_en_o,
  output logic   store_en_o,
  output cnt_t   depth_o,
  output logic   busy_o,
  output phase_e phase_o
);

  phase_e state_q, state_d;
  cnt_t   depth_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      PH_IDLE: begin
        if (start_i) begin
          state_d = PH_LOAD;
        end
      end
      PH_LOAD: begin
        if (loaded_i) begin
          state_d = PH_PUSH;
        end
      end
      PH_PUSH: begin
        if (pushed_i) begin
          state_d = PH_STORE;
        end
      end
      PH_STORE: begin
        if (stored_i) begin
          state_d = PH_IDLE;
        end
      end
      default: state_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge buffer_clock or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PH_IDLE;
    end else if (clear_i) begin
      state_q <= PH_IDLE;  // Abort whatever phase is running
    end else begin
      state_q <= state_d;
    end
  end

  // Effective depth is fixed for the whole case
  always_ff @(posedge buffer_clock or negedge rst_ni) begin
    if (!rst_ni) begin
      depth_q <= '0;
    end else if (clear_i) begin
      depth_q <= '0;
    end else if (state_q == PH_IDLE && start_i) begin
      depth_q <= (leftover_i == '0) ? cnt_t'(Depth) : leftover_i;
    end
  end

  assign load_en_o  = (state_q == PH_LOAD);
  assign push_en_o  = (state_q == PH_PUSH);
  assign store_en_o = (state_q == PH_STORE);
  assign busy_o     = (state_q != PH_IDLE);
  assign depth_o    = depth_q;
  assign phase_o    = state_q;

  // A new case may only begin once the previous one is done
  a_start_idle: assert property (
    @(posedge buffer_clock) disable iff (!rst_ni || clear_i)
    start_i |-> !busy_o
  ) else $error("start_i pulsed while busy");

endmodule : z_buffer_ctrl

// File: source/z_store_packer.sv
/*
 * Z buffer store packer
 */

module z_store_packer
  import z_buffer_pkg::*;
#(
  parameter int unsigned Depth = 4,
  parameter int unsigned Width = 4
) (
  input  logic                   buffer_clock,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   store_en_i,
  input  logic                   store_ready_i,
  input  elem_t [Depth-1:0]      col_i,
  input  cnt_t                   depth_i,
  output elem_t [Depth-1:0]      z_data_o,
  output logic  [Depth-1:0]      z_strb_o,
  output logic                   z_valid_o,
  output logic                   store_shift_o,
  output logic                   stored_o,
  output logic                   done_o
);

  cnt_t beat_cnt_q;  // Beats accepted so far

  // Row Depth-1-d holds beat position d
  always_comb begin
    for (int d = 0; d < Depth; d++) begin
      z_data_o[d] = col_i[Depth-1-d];
      z_strb_o[d] = (cnt_t'(d) < depth_i);
    end
  end

  assign z_valid_o     = store_en_i;
  assign store_shift_o = store_en_i & store_ready_i;  // Beat accepted

  always_ff @(posedge buffer_clock or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (clear_i || stored_o) begin
      beat_cnt_q <= '0;
    end else if (store_shift_o) begin
      beat_cnt_q <= beat_cnt_q + cnt_t'(1);
    end
  end

  assign stored_o = store_shift_o & (beat_cnt_q == cnt_t'(Width - 1));
  assign done_o   = stored_o;  // Tile fully drained

  // A stalled beat must not move, so the tile may not shift under it
  a_hold_beat: assert property (
    @(posedge buffer_clock) disable iff (!rst_ni || clear_i)
    (z_valid_o && !store_ready_i) |=> (z_valid_o && $stable(z_data_o))
  ) else $error("Store beat changed while stalled");

endmodule : z_store_packer

// File: source/z_buffer_top.sv
/*
 * Z buffer top level
 */

module z_buffer_top
  import z_buffer_pkg::*;
#(
  parameter int unsigned Depth = 4,
  parameter int unsigned Width = 4
) (
  input  logic                   buffer_clock,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  input  cnt_t                   leftover_i,
  // Memory load beat
  input  elem_t [Depth-1:0]      y_data_i,
  input  logic                   y_valid_i,
  // Array result row
  input  elem_t [Width-1:0]      z_row_i,
  input  logic                   z_row_valid_i,
  input  logic                   store_ready_i,
  // Row toward the array
  output elem_t [Width-1:0]      y_row_o,
  output logic                   y_row_valid_o,
  // Store beat
  output elem_t [Depth-1:0]      z_data_o,
  output logic  [Depth-1:0]      z_strb_o,
  output logic                   z_valid_o,
  output logic                   busy_o,
  output logic                   done_o
);

  logic              load_we;
  cnt_t              load_col;
  elem_t [Depth-1:0] load_data;
  logic              loaded;
  logic              load_en;
  logic              push_en;
  logic              store_en;
  cnt_t              depth;
  logic              pushed;
  elem_t [Depth-1:0] col;
  logic              store_shift;
  logic              stored;
  phase_e            phase;  // Debug probe, current phase

  z_row_loader #(
    .Depth ( Depth ),
    .Width ( Width )
  ) z_row_loader_i (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .load_en_i    ( load_en      ),
    .y_valid_i    ( y_valid_i    ),
    .y_data_i     ( y_data_i     ),
    .depth_i      ( depth        ),
    .load_we_o    ( load_we      ),
    .load_col_o   ( load_col     ),
    .load_data_o  ( load_data    ),
    .loaded_o     ( loaded       )
  );

  z_buffer_ctrl #(
    .Depth ( Depth )
  ) z_buffer_ctrl_i (
    .buffer_clock ( buffer_clock ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .start_i      ( start_i      ),
    .leftover_i   ( leftover_i   ),
    .loaded_i     ( loaded       ),
    .pushed_i     ( pushed       ),
    .stored_i     ( stored       ),
    .load_en_o    ( load_en      ),
    .push_en_o    ( push_en      ),
    .store_en_o   ( store_en     ),
    .depth_o      ( depth        ),
    .busy_o       ( busy_o       ),
    .phase_o      ( phase        )
  );

  z_tile_buffer #(
    .Depth ( Depth ),
    .Width ( Width )
  ) z_tile_buffer_i (
    .buffer_clock  ( buffer_clock  ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .load_we_i     ( load_we       ),
    .load_col_i    ( load_col      ),
    .load_data_i   ( load_data     ),
    .push_en_i     ( push_en       ),
    .z_row_valid_i ( z_row_valid_i ),
    .z_row_i       ( z_row_i       ),
    .store_shift_i ( store_shift   ),
    .y_row_o       ( y_row_o       ),
    .y_row_valid_o ( y_row_valid_o ),
    .col_o         ( col           ),
    .pushed_o      ( pushed        )
  );

  z_store_packer #(
    .Depth ( Depth ),
    .Width ( Width )
  ) z_store_packer_i (
    .buffer_clock  ( buffer_clock  ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .store_en_i    ( store_en      ),
    .store_ready_i ( store_ready_i ),
    .col_i         ( col           ),
    .depth_i       ( depth         ),
    .z_data_o      ( z_data_o      ),
    .z_strb_o      ( z_strb_o      ),
    .z_valid_o     ( z_valid_o     ),
    .store_shift_o ( store_shift   ),
    .stored_o      ( stored        ),
    .done_o        ( done_o        )
  );

endmodule : z_buffer_top

// File: test/tb_z_buffer.sv
/*
 * Z buffer testbench
 */

module tb_z_buffer
  import z_buffer_pkg::*;
();

  localparam int unsigned tile_depth  = 4;
  localparam int unsigned tile_width  = 4;
  localparam int unsigned num_cases   = 6;
  localparam int unsigned cycle_limit = num_cases * (2 * (tile_width + tile_depth) + 40);

  logic buffer_clock = 1'b0;
  logic rst_ni, clear_i, start_i, y_valid_i, z_row_valid_i, store_ready_i;
  cnt_t leftover_i;
  elem_t [tile_depth-1:0] y_data_i;
  elem_t [tile_width-1:0] z_row_i;
  elem_t [tile_width-1:0] y_row_o;
  elem_t [tile_depth-1:0] z_data_o;
  logic  [tile_depth-1:0] z_strb_o;
  logic y_row_valid_o, z_valid_o, busy_o, done_o;

  int push_errs = 0;
  int data_errs = 0;
  int strb_errs = 0;
  int ctrl_errs = 0;
  int done_seen = 0;
  int cycle_cnt = 0;
  int unsigned rand_seed;

  // Case table, abort 1 clears during load and 2 during push
  cnt_t                   left_tab  [num_cases];
  int                     abort_tab [num_cases];
  elem_t [tile_depth-1:0] load_tab  [num_cases][tile_width];  // Memory beats
  elem_t [tile_width-1:0] res_tab   [num_cases][tile_depth];  // Array result rows

  z_buffer_top #(
    .Depth ( tile_depth ),
    .Width ( tile_width )
  ) z_buffer_top_i (.*);

  always #4 buffer_clock = ~buffer_clock;

  always @(negedge buffer_clock) begin
    if (done_o) done_seen++;  // Outputs settled by the falling edge
  end

  always @(posedge buffer_clock) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_row(input elem_t [tile_width-1:0] got, exp, input int k);
    if (got !== exp) begin
      push_errs++;
      $display("MISMATCH @%0t: push row %0d got %h expected %h", $time, k, got, exp);
    end
  endtask

  task automatic check_beat(input elem_t [tile_depth-1:0] got, exp, input int j);
    if (got !== exp) begin
      data_errs++;
      $display("MISMATCH @%0t: store beat %0d got %h expected %h", $time, j, got, exp);
    end
  endtask

  task automatic check_strb(input logic [tile_depth-1:0] got, exp, input int j);
    if (got !== exp) begin
      strb_errs++;
      $display("MISMATCH @%0t: strobe of beat %0d got %b expected %b", $time, j, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      ctrl_errs++;
      $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_phase(input phase_e got, exp, input string what);
    if (got !== exp) begin
      ctrl_errs++;
      $display("MISMATCH @%0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic build_table();
    left_tab  = '{8'd0, 8'd3, 8'd0, 8'd1, 8'd0, 8'd2};
    abort_tab = '{0, 0, 1, 0, 2, 0};
    for (int c = 0; c < num_cases; c++) begin
      for (int w = 0; w < tile_width; w++) begin
        for (int d = 0; d < tile_depth; d++) begin
          load_tab[c][w][d] = elem_t'(((c + 1) << 12) | (w << 8) | (d << 4) | 1);
          res_tab[c][d][w]  = elem_t'(16'h8000 | (c << 12) | (d << 8) | (w << 4) | 5);
        end
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge buffer_clock);
    #1;
  endtask

  task automatic idle_checks(input string where);
    check_flag(busy_o, 1'b0, {"busy_o ", where});
    check_flag(z_valid_o, 1'b0, {"z_valid_o ", where});
    check_flag(y_row_valid_o, 1'b0, {"y_row_valid_o ", where});
    check_flag(done_o, 1'b0, {"done_o ", where});
    check_phase(z_buffer_top_i.phase, PH_IDLE, {"phase ", where});
  endtask

  // Synchronous clear in the middle of a case
  task automatic abort_case(input int c);
    int dones_before;
    dones_before = done_seen;
    next_cycle();
    clear_i       = 1'b1;
    y_valid_i     = 1'b0;
    z_row_valid_i = 1'b0;
    next_cycle();
    clear_i = 1'b0;
    @(negedge buffer_clock);
    idle_checks("after clear");
    if (done_seen != dones_before) begin
      ctrl_errs++;
      $display("Case %0d: done_o pulsed although the case was cleared", c);
    end
  endtask

  task automatic run_case(input int c);
    cnt_t                   eff;
    int                     w, k, j, dones_before;
    elem_t [tile_width-1:0] exp_row;
    elem_t [tile_depth-1:0] exp_beat;
    logic  [tile_depth-1:0] exp_strb;

    eff = (left_tab[c] == '0) ? cnt_t'(tile_depth) : left_tab[c];
    dones_before = done_seen;
    for (int d = 0; d < tile_depth; d++) begin
      exp_strb[d] = (d < eff);
    end
    next_cycle();
    start_i    = 1'b1;
    leftover_i = left_tab[c];
    @(negedge buffer_clock);
    check_flag(busy_o, 1'b0, "busy_o before start");

    w = 0;
    while (w < tile_width) begin
      next_cycle();
      start_i       = 1'b0;
      leftover_i    = cnt_t'($urandom_range(tile_depth));  // Only sampled at start
      y_valid_i     = ($urandom_range(3) != 0);
      y_data_i      = load_tab[c][w];
      z_row_valid_i = $urandom_range(1);
      @(negedge buffer_clock);
      check_flag(busy_o, 1'b1, "busy_o in load");
      check_flag(y_row_valid_o, 1'b0, "y_row_valid_o in load");
      check_phase(z_buffer_top_i.phase, PH_LOAD, "phase in load");
      w += y_valid_i;
      if (abort_tab[c] == 1 && w == 2) begin
        abort_case(c);
        return;
      end
    end

    // Push k sends element k of every beat, the array row fills from below
    k = 0;
    while (k < tile_depth) begin
      next_cycle();
      y_valid_i     = 1'b0;
      z_row_valid_i = ($urandom_range(3) != 0);
      z_row_i       = res_tab[c][k];
      for (int x = 0; x < tile_width; x++) begin
        exp_row[x] = (k < eff) ? load_tab[c][x][k] : '0;
      end
      @(negedge buffer_clock);
      check_flag(y_row_valid_o, z_row_valid_i, "y_row_valid_o in push");
      check_row(y_row_o, exp_row, k);
      check_phase(z_buffer_top_i.phase, PH_PUSH, "phase in push");
      k += z_row_valid_i;
      if (abort_tab[c] == 2 && k == 2) begin
        abort_case(c);
        return;
      end
    end

    // Store beat j holds element j of every result row
    j = 0;
    while (j < tile_width) begin
      next_cycle();
      z_row_valid_i = $urandom_range(1);  // Stray array strobes, ignored here
      store_ready_i = ($urandom_range(3) != 0);
      for (int d = 0; d < tile_depth; d++) begin
        exp_beat[d] = res_tab[c][d][j];
      end
      @(negedge buffer_clock);
      check_flag(z_valid_o, 1'b1, "z_valid_o in store");
      check_flag(y_row_valid_o, 1'b0, "y_row_valid_o in store");
      check_phase(z_buffer_top_i.phase, PH_STORE, "phase in store");
      check_beat(z_data_o, exp_beat, j);
      check_strb(z_strb_o, exp_strb, j);
      check_flag(done_o, store_ready_i && j == tile_width - 1, "done_o in store");
      j += store_ready_i;
    end

    next_cycle();
    store_ready_i = $urandom_range(1);
    @(negedge buffer_clock);
    idle_checks("after done");
    if (done_seen != dones_before + 1) begin
      ctrl_errs++;
      $display("Case %0d: done_o pulsed %0d times, not once", c, done_seen - dones_before);
    end
  endtask

  initial begin
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    start_i       = 1'b0;
    leftover_i    = '0;
    y_data_i      = '0;
    y_valid_i     = 1'b0;
    z_row_i       = '0;
    z_row_valid_i = 1'b0;
    store_ready_i = 1'b0;
    rand_seed     = $urandom(88773);
    build_table();
    repeat (5) @(posedge buffer_clock);
    #1;
    rst_ni = 1'b1;
    @(negedge buffer_clock);
    idle_checks("after reset");
    for (int c = 0; c < num_cases; c++) begin
      run_case(c);
    end
    $display("Errors: push %0d, data %0d, strobe %0d, control %0d",
             push_errs, data_errs, strb_errs, ctrl_errs);
    if (push_errs + data_errs + strb_errs + ctrl_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_z_buffer

// File: filelist.f
source/z_buffer_pkg.sv
source/z_row_loader.sv
source/z_tile_buffer.sv
source/z_buffer_ctrl.sv
source/z_store_packer.sv
source/z_buffer_top.sv
test/tb_z_buffer.sv
